//--- obj_defines.svh
//----------------------------------------------------------
// Object engine sizes
//----------------------------------------------------------
`ifndef OBJ_DEFINES_SVH
`define OBJ_DEFINES_SVH

// Entries in the attribute RAM
`define OBJ_COUNT     32

// Objects kept for one line
`define OBJ_MAX_HITS  6

// Visible pixels, h bit 8 low
`define OBJ_LINE_W    256

// Clocks in a whole line
`define OBJ_H_TOTAL   384

// Object width and height in pixels
`define OBJ_SIZE      16

`endif

//--- obj_pkg.sv
//----------------------------------------------------------
// Object engine types
//----------------------------------------------------------
`default_nettype none

package obj_pkg;

	// One attribute entry, CPU byte 0 in the top bits
	typedef struct packed {
		logic [7:0] y;
		logic       flip_y;
		logic       flip_x;
		logic [5:0] code;
		logic [3:0] color;
		logic [3:0] reserved;
		logic [7:0] x;
	} obj_attr_t;

	// Kept object, row already y-flipped
	typedef struct packed {
		logic [5:0] code;
		logic [3:0] row;
		logic       flip_x;
		logic [3:0] color;
		logic [7:0] x;
	} obj_hit_t;

	// CPU strobe port
	typedef struct packed {
		logic [6:0] addr;
		logic [7:0] wdata;
		logic       we;
		logic       re;
	} cpu_bus_t;

	// Pattern download, addr bit 0 picks the high byte
	typedef struct packed {
		logic [12:0] addr;
		logic [7:0]  data;
		logic        we;
	} dl_bus_t;

	// Beam position from the video timing
	typedef struct packed {
		logic [8:0] h;
		logic [7:0] v;
	} video_pos_t;

	// Line buffer pixel, pix 0 is transparent
	typedef struct packed {
		logic [3:0] color;
		logic [1:0] pix;
	} obj_pix_t;

endpackage

`default_nettype wire

//--- obj_attr_ram.sv
//----------------------------------------------------------
// Object attribute RAM
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "obj_defines.svh"

module obj_attr_ram (
	input  wire                  CLK_24M,
	input  wire                  RST_4L,
	input  obj_pkg::cpu_bus_t    cpu,
	output logic [7:0]           cpu_rdata,
	input  wire  [4:0]           scan_idx,
	output obj_pkg::obj_attr_t   scan_attr
);

	// One 32-bit word per object
	logic [31:0] mem [0:`OBJ_COUNT-1];

	// Byte 0 sits in bits 31:24, so the lane offset is inverted
	logic [4:0]  lane_off;
	logic [31:0] cpu_word;

	assign lane_off = {~cpu.addr[1:0], 3'b000};
	assign cpu_word = mem[cpu.addr[6:2]];

	// CPU byte writes
	always_ff @(posedge CLK_24M)
	begin
		if (cpu.we)
			mem[cpu.addr[6:2]][lane_off +: 8] <= cpu.wdata;
	end

	// CPU read data, valid the clock after re
	always_ff @(posedge CLK_24M or negedge RST_4L)
	begin
		if (!RST_4L)
			cpu_rdata <= 8'h00;
		else if (cpu.re)
			cpu_rdata <= cpu_word[lane_off +: 8];
	end

	// Scanner side, whole entry one clock after the index
	always_ff @(posedge CLK_24M)
	begin
		scan_attr <= mem[scan_idx];
	end

endmodule

`default_nettype wire

//--- obj_pattern_rom.sv
//----------------------------------------------------------
// Downloadable pattern store
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module obj_pattern_rom (
	input  wire                CLK_24M,
	input  obj_pkg::dl_bus_t   dl,
	input  wire  [11:0]        rd_addr,
	output logic [15:0]        rd_data
);

	// Plane 1 in the high lane, plane 0 in the low lane
	logic [7:0] lane_hi [0:4095];
	logic [7:0] lane_lo [0:4095];

	// Download side, odd byte address goes high
	always_ff @(posedge CLK_24M)
	begin
		if (dl.we && dl.addr[0])
			lane_hi[dl.addr[12:1]] <= dl.data;
		if (dl.we && !dl.addr[0])
			lane_lo[dl.addr[12:1]] <= dl.data;
	end

	// Renderer side, one clock latency
	always_ff @(posedge CLK_24M)
	begin
		rd_data <= {lane_hi[rd_addr], lane_lo[rd_addr]};
	end

endmodule

`default_nettype wire

//--- obj_line_scan.sv
//----------------------------------------------------------
// Object line scanner
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "obj_defines.svh"

module obj_line_scan (
	input  wire                   CLK_24M,
	input  wire                   RST_4L,
	input  obj_pkg::video_pos_t   pos,
	output logic [4:0]            scan_idx,
	input  obj_pkg::obj_attr_t    scan_attr,
	output obj_pkg::obj_hit_t     hits [`OBJ_MAX_HITS],
	output logic [2:0]            hit_count
);

	import obj_pkg::*;

	logic       scan_vld;
	logic [7:0] next_v;
	logic [7:0] dy;
	logic       is_hit;
	logic       take;

	// Object h[4:0] is read during h 0..31
	assign scan_idx = pos.h[4:0];

	// Scan targets the following line
	assign next_v = pos.v + 8'd1;
	assign dy     = next_v - scan_attr.y;
	assign is_hit = scan_vld && (dy < 8'(`OBJ_SIZE));

	// Stop appending once the list is full
	assign take = is_hit && (hit_count < 3'(`OBJ_MAX_HITS));

	//----------------------------------------------------------
	// Control
	//----------------------------------------------------------
	always_ff @(posedge CLK_24M or negedge RST_4L)
	begin
		if (!RST_4L)
		begin
			scan_vld  <= 1'b0;
			hit_count <= 3'd0;
		end
		else
		begin
			// RAM data lags the index by one clock
			scan_vld <= (pos.h < 9'(`OBJ_COUNT));
			if (pos.h == 9'd0)
				hit_count <= 3'd0;
			else if (take)
				hit_count <= hit_count + 3'd1;
		end
	end

	//----------------------------------------------------------
	// Hit list
	//----------------------------------------------------------
	always_ff @(posedge CLK_24M)
	begin
		if (take)
		begin
			hits[hit_count].code   <= scan_attr.code;
			// y-flip turns row d into 15 - d
			hits[hit_count].row    <= scan_attr.flip_y ? ~dy[3:0] : dy[3:0];
			hits[hit_count].flip_x <= scan_attr.flip_x;
			hits[hit_count].color  <= scan_attr.color;
			hits[hit_count].x      <= scan_attr.x;
		end
	end

endmodule

`default_nettype wire

//--- obj_row_render.sv
//----------------------------------------------------------
// Object row renderer
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "obj_defines.svh"

module obj_row_render (
	input  wire                   CLK_24M,
	input  wire                   RST_4L,
	input  obj_pkg::video_pos_t   pos,
	input  obj_pkg::obj_hit_t     hits [`OBJ_MAX_HITS],
	input  wire  [2:0]            hit_count,
	output logic [11:0]           rom_addr,
	input  wire  [15:0]           rom_data,
	output logic [7:0]            wr_addr,
	output obj_pkg::obj_pix_t     wr_pix,
	output logic                  wr_en,
	input  obj_pkg::obj_pix_t     wr_old
);

	import obj_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_SHIFT} state_t;

	state_t     state;
	logic [2:0] idx;
	logic       half;
	logic [2:0] pcnt;
	logic       wr_cand;
	obj_hit_t   cur_hit;
	logic [2:0] bit_sel;
	logic [1:0] pix;
	logic [8:0] scr_x;

	assign cur_hit = hits[idx];

	// x-flip fetches the right half first
	assign rom_addr = {1'b0, cur_hit.code, cur_hit.row, half ^ cur_hit.flip_x};

	// MSB is leftmost and x-flip walks from the LSB
	assign bit_sel = cur_hit.flip_x ? pcnt : ~pcnt;
	assign pix     = {rom_data[{1'b1, bit_sel}], rom_data[{1'b0, bit_sel}]};

	// Screen column with bit 8 set off the right edge
	assign scr_x = {1'b0, cur_hit.x} + {5'd0, half, pcnt};

	// Covered test against the current buffer contents
	assign wr_en = wr_cand && (wr_old.pix == 2'd0);

	//----------------------------------------------------------
	// Sequencer
	//----------------------------------------------------------
	always_ff @(posedge CLK_24M or negedge RST_4L)
	begin
		if (!RST_4L)
		begin
			state   <= ST_IDLE;
			idx     <= 3'd0;
			half    <= 1'b0;
			pcnt    <= 3'd0;
			wr_cand <= 1'b0;
		end
		else
		begin
			wr_cand <= (state == ST_SHIFT) && !scr_x[8] && (pix != 2'd0);
			case (state)
				ST_IDLE:
				begin
					// Blank edge starts the row
					if (pos.h == 9'(`OBJ_LINE_W) && hit_count != 3'd0)
					begin
						idx   <= 3'd0;
						half  <= 1'b0;
						state <= ST_FETCH;
					end
				end
				ST_FETCH:
				begin
					// ROM word lands next clock
					pcnt  <= 3'd0;
					state <= ST_SHIFT;
				end
				default:
				begin
					pcnt <= pcnt + 3'd1;
					if (pcnt == 3'd7)
					begin
						half  <= ~half;
						state <= ST_FETCH;
						if (half)
						begin
							idx <= idx + 3'd1;
							if (idx + 3'd1 == hit_count)
								state <= ST_IDLE;
						end
					end
				end
			endcase
		end
	end

	// Write address and pixel go out a clock ahead of the write
	always_ff @(posedge CLK_24M)
	begin
		wr_addr      <= scr_x[7:0];
		wr_pix.color <= cur_hit.color;
		wr_pix.pix   <= pix;
	end

endmodule

`default_nettype wire

//--- obj_line_buffer.sv
//----------------------------------------------------------
// Double line buffer
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "obj_defines.svh"

module obj_line_buffer (
	input  wire                   CLK_24M,
	input  wire                   RST_4L,
	input  obj_pkg::video_pos_t   pos,
	input  wire  [7:0]            wr_addr,
	input  obj_pkg::obj_pix_t     wr_pix,
	input  wire                   wr_en,
	output obj_pkg::obj_pix_t     wr_old,
	output obj_pkg::obj_pix_t     out_pix
);

	import obj_pkg::*;

	// Bank in the top address bit
	obj_pix_t   mem [0:2*`OBJ_LINE_W-1];
	logic       disp;
	logic [8:0] front_addr;
	logic [8:0] back_addr;

	// Front bank follows v, renderer fills the other
	assign disp       = (pos.h < 9'(`OBJ_LINE_W));
	assign front_addr = {pos.v[0], pos.h[7:0]};
	assign back_addr  = {~pos.v[0], wr_addr};

	// Read-before-write for the covered test
	assign wr_old = mem[back_addr];

	// Display clears behind itself, render only writes in blank
	always_ff @(posedge CLK_24M)
	begin
		if (disp)
			mem[front_addr] <= '0;
		else if (wr_en)
			mem[back_addr] <= wr_pix;
	end

	// Output register, zero outside the visible part
	always_ff @(posedge CLK_24M or negedge RST_4L)
	begin
		if (!RST_4L)
			out_pix <= '0;
		else if (disp)
			out_pix <= mem[front_addr];
		else
			out_pix <= '0;
	end

endmodule

`default_nettype wire

//--- dkong_obj_top.sv
//----------------------------------------------------------
// Sprite engine top
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "obj_defines.svh"

module dkong_obj_top (
	input  wire                   CLK_24M,
	input  wire                   RST_4L,
	input  obj_pkg::cpu_bus_t     cpu,
	output logic [7:0]            cpu_rdata,
	input  obj_pkg::dl_bus_t      dl,
	input  obj_pkg::video_pos_t   pos,
	output obj_pkg::obj_pix_t     obj_pix
);

	import obj_pkg::*;

	// Scan path
	logic [4:0]  scan_idx;
	obj_attr_t   scan_attr;
	obj_hit_t    hits [`OBJ_MAX_HITS];
	logic [2:0]  hit_count;

	// Pattern fetch
	logic [11:0] rom_addr;
	logic [15:0] rom_data;

	// Render to line buffer
	logic [7:0]  wr_addr;
	obj_pix_t    wr_pix;
	logic        wr_en;
	obj_pix_t    wr_old;

	obj_attr_ram u_attr_ram (
		.CLK_24M   (CLK_24M),
		.RST_4L    (RST_4L),
		.cpu       (cpu),
		.cpu_rdata (cpu_rdata),
		.scan_idx  (scan_idx),
		.scan_attr (scan_attr)
	);

	obj_pattern_rom u_pattern_rom (
		.CLK_24M (CLK_24M),
		.dl      (dl),
		.rd_addr (rom_addr),
		.rd_data (rom_data)
	);

	obj_line_scan u_line_scan (
		.CLK_24M   (CLK_24M),
		.RST_4L    (RST_4L),
		.pos       (pos),
		.scan_idx  (scan_idx),
		.scan_attr (scan_attr),
		.hits      (hits),
		.hit_count (hit_count)
	);

	obj_row_render u_row_render (
		.CLK_24M   (CLK_24M),
		.RST_4L    (RST_4L),
		.pos       (pos),
		.hits      (hits),
		.hit_count (hit_count),
		.rom_addr  (rom_addr),
		.rom_data  (rom_data),
		.wr_addr   (wr_addr),
		.wr_pix    (wr_pix),
		.wr_en     (wr_en),
		.wr_old    (wr_old)
	);

	obj_line_buffer u_line_buffer (
		.CLK_24M (CLK_24M),
		.RST_4L  (RST_4L),
		.pos     (pos),
		.wr_addr (wr_addr),
		.wr_pix  (wr_pix),
		.wr_en   (wr_en),
		.wr_old  (wr_old),
		.out_pix (obj_pix)
	);

endmodule

`default_nettype wire

//--- tb_obj.sv
//----------------------------------------------------------
// Sprite engine testbench
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "obj_defines.svh"

module tb_obj;

	import obj_pkg::*;

	localparam int CLK_PERIOD   = 40;
	// Download and readback, then seven cases of about three lines each
	localparam int RUN_LINES    = 56;
	localparam int MARGIN_LINES = 16;
	localparam int WATCHDOG_NS  = (RUN_LINES + MARGIN_LINES) * `OBJ_H_TOTAL * CLK_PERIOD;
	// Case start point in horizontal blank
	localparam logic [8:0] SYNC_H = 9'd300;

	logic        CLK_24M = 1'b0;
	logic        RST_4L;
	cpu_bus_t    cpu;
	logic [7:0]  cpu_rdata;
	dl_bus_t     dl;
	video_pos_t  pos = '0;
	obj_pix_t    obj_pix;

	// Copies of everything loaded into the DUT
	logic [15:0] pat_copy [0:4095];
	logic [7:0]  attr_copy [0:4*`OBJ_COUNT-1];

	// Captured and predicted visible line
	obj_pix_t    cap_line [0:`OBJ_LINE_W-1];
	obj_pix_t    exp_line [0:`OBJ_LINE_W-1];

	logic [31:0] rng = 32'h937b;
	int          err_cnt = 0;

	dkong_obj_top UUT (
		.CLK_24M   (CLK_24M),
		.RST_4L    (RST_4L),
		.cpu       (cpu),
		.cpu_rdata (cpu_rdata),
		.dl        (dl),
		.pos       (pos),
		.obj_pix   (obj_pix)
	);

	always #(CLK_PERIOD / 2) CLK_24M = ~CLK_24M;

	//----------------------------------------------------------
	// Beam counter and pixel capture
	//----------------------------------------------------------
	always @(negedge CLK_24M)
	begin
		// obj_pix belongs to the position sampled at the last rising edge
		if (pos.h < 9'(`OBJ_LINE_W))
			cap_line[pos.h[7:0]] <= obj_pix;
		else
			// Blank shows no object pixel
			compare_pix("obj_pix", obj_pix, '0, int'(pos.h), pos.v);
		if (pos.h == 9'(`OBJ_H_TOTAL - 1))
		begin
			pos.h <= 9'd0;
			pos.v <= pos.v + 8'd1;
		end
		else
			pos.h <= pos.h + 9'd1;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] r;
		r = s ^ (s << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	function automatic obj_attr_t make_attr(input logic [7:0] y, input logic fy,
		input logic fx, input logic [5:0] code, input logic [3:0] color, input logic [7:0] x);
		obj_attr_t a;
		a = '0;
		a.y = y;
		a.flip_y = fy;
		a.flip_x = fx;
		a.code = code;
		a.color = color;
		a.x = x;
		return a;
	endfunction

	// Expected line from the copies and the scan of the line before
	function automatic void build_expected(input logic [7:0] line);
		obj_attr_t  a;
		logic [7:0] d;
		logic [3:0] row;
		logic [3:0] p;
		logic [8:0] sx;
		logic [15:0] w;
		logic [7:0] plane1;
		logic [7:0] plane0;
		logic [2:0] b;
		logic [1:0] px;
		int         kept;
		for (int h = 0; h < `OBJ_LINE_W; h++)
			exp_line[h[7:0]] = '0;
		kept = 0;
		for (int i = 0; i < `OBJ_COUNT; i++)
		begin
			a = {attr_copy[{i[4:0], 2'd0}], attr_copy[{i[4:0], 2'd1}],
				attr_copy[{i[4:0], 2'd2}], attr_copy[{i[4:0], 2'd3}]};
			d = line - a.y;
			if (kept < `OBJ_MAX_HITS && d < 8'(`OBJ_SIZE))
			begin
				kept++;
				row = a.flip_y ? 4'd15 - d[3:0] : d[3:0];
				for (int k = 0; k < `OBJ_SIZE; k++)
				begin
					sx = {1'b0, a.x} + {5'd0, k[3:0]};
					// Pattern pixel index counted from the left
					p = a.flip_x ? 4'd15 - k[3:0] : k[3:0];
					w = pat_copy[{1'b0, a.code, row, p[3]}];
					plane1 = w[15:8];
					plane0 = w[7:0];
					// Leftmost pixel in each byte's MSB
					b = 3'd7 - p[2:0];
					px = {plane1[b], plane0[b]};
					// Earlier object keeps its pixel
					if (!sx[8] && px != 2'd0 && exp_line[sx[7:0]].pix == 2'd0)
					begin
						exp_line[sx[7:0]].color = a.color;
						exp_line[sx[7:0]].pix = px;
					end
				end
			end
		end
	endfunction

	//----------------------------------------------------------
	// Compare and bus tasks
	//----------------------------------------------------------
	task automatic compare_pix(input string name, input obj_pix_t got, input obj_pix_t exp,
		input int h, input logic [7:0] v);
		if (got !== exp)
		begin
			err_cnt++;
			$display("mismatch %s h=%0d v=%0d got %h expected %h", name, h, v, got, exp);
		end
	endtask

	task automatic compare_byte(input string name, input logic [7:0] got,
		input logic [7:0] exp, input logic [6:0] addr);
		if (got !== exp)
		begin
			err_cnt++;
			$display("mismatch %s addr=%h got %h expected %h", name, addr, got, exp);
		end
	endtask

	task automatic cpu_write(input logic [6:0] addr, input logic [7:0] data);
		@(negedge CLK_24M);
		cpu.addr = addr;
		cpu.wdata = data;
		cpu.we = 1'b1;
		@(negedge CLK_24M);
		cpu.we = 1'b0;
		attr_copy[addr] = data;
	endtask

	// Read data lands on the rising edge after re
	task automatic cpu_read(input logic [6:0] addr, output logic [7:0] data);
		@(negedge CLK_24M);
		cpu.addr = addr;
		cpu.re = 1'b1;
		@(negedge CLK_24M);
		cpu.re = 1'b0;
		data = cpu_rdata;
	endtask

	// Whole store with the low byte of each word first
	task automatic download_patterns();
		logic [15:0] w;
		for (int a = 0; a < 4096; a++)
		begin
			rng = xorshift32(rng);
			w = rng[15:0];
			pat_copy[a[11:0]] = w;
			for (int b = 0; b < 2; b++)
			begin
				@(negedge CLK_24M);
				dl.addr = {a[11:0], b[0]};
				dl.data = b[0] ? w[15:8] : w[7:0];
				dl.we = 1'b1;
			end
		end
		@(negedge CLK_24M);
		dl.we = 1'b0;
	endtask

	task automatic set_object(input logic [4:0] idx, input obj_attr_t a);
		cpu_write({idx, 2'd0}, a[31:24]);
		cpu_write({idx, 2'd1}, a[23:16]);
		cpu_write({idx, 2'd2}, a[15:8]);
		cpu_write({idx, 2'd3}, a[7:0]);
	endtask

	// Sync to blank and park all objects away from the checked line
	task automatic start_case(output logic [7:0] tgt);
		@(negedge CLK_24M);
		while (pos.h != SYNC_H)
			@(negedge CLK_24M);
		// Next line may still scan old entries
		tgt = pos.v + 8'd3;
		for (int i = 0; i < `OBJ_COUNT; i++)
			cpu_write({i[4:0], 2'd0}, tgt + 8'd128);
	endtask

	task automatic check_line(input logic [7:0] tgt);
		@(negedge CLK_24M);
		// Line is complete once h leaves the visible part
		while (pos.v != tgt || pos.h != 9'(`OBJ_LINE_W))
			@(negedge CLK_24M);
		build_expected(tgt);
		for (int h = 0; h < `OBJ_LINE_W; h++)
			compare_pix("obj_pix", cap_line[h[7:0]], exp_line[h[7:0]], h, tgt);
	endtask

	//----------------------------------------------------------
	// Directed cases
	//----------------------------------------------------------
	task automatic attr_readback();
		logic [7:0] rd;
		for (int i = 0; i < 4 * `OBJ_COUNT; i++)
		begin
			rng = xorshift32(rng);
			cpu_write(i[6:0], rng[7:0]);
		end
		for (int i = 0; i < 4 * `OBJ_COUNT; i++)
		begin
			cpu_read(i[6:0], rd);
			compare_byte("cpu_rdata", rd, attr_copy[i[6:0]], i[6:0]);
		end
	endtask

	task automatic single_object();
		logic [7:0] tgt;
		start_case(tgt);
		set_object(5'd3, make_attr(tgt - 8'd5, 1'b0, 1'b0, 6'h12, 4'h9, 8'd40));
		check_line(tgt);
	endtask

	// x-flip and y-flip alone and then both
	task automatic flipped_objects();
		logic [7:0] tgt;
		for (int m = 1; m < 4; m++)
		begin
			start_case(tgt);
			set_object(5'd7, make_attr(tgt - 8'd3, m[1], m[0], 6'h21, 4'h5, 8'd100));
			check_line(tgt);
		end
	endtask

	task automatic overlap_priority();
		logic [7:0] tgt;
		start_case(tgt);
		set_object(5'd2, make_attr(tgt - 8'd2, 1'b0, 1'b0, 6'h05, 4'h3, 8'd60));
		set_object(5'd9, make_attr(tgt - 8'd10, 1'b1, 1'b0, 6'h2a, 4'hc, 8'd68));
		check_line(tgt);
	endtask

	// Eight objects on one line with only six kept
	task automatic hit_limit();
		logic [7:0] tgt;
		start_case(tgt);
		for (int j = 0; j < 8; j++)
			set_object(5'(4 * j + 1), make_attr(tgt - 8'(j), 1'b0, j[0], 6'(j + 8),
				4'(j + 1), 8'(8 + 30 * j)));
		check_line(tgt);
	endtask

	task automatic right_edge_clip();
		logic [7:0] tgt;
		start_case(tgt);
		set_object(5'd14, make_attr(tgt - 8'd4, 1'b0, 1'b0, 6'h30, 4'ha, 8'd248));
		check_line(tgt);
		// Same object one row lower
		check_line(tgt + 8'd1);
	endtask

	//----------------------------------------------------------
	// Main sequence and watchdog
	//----------------------------------------------------------
	initial
	begin
		cpu = '0;
		dl = '0;
		RST_4L = 1'b0;
		repeat (3) @(negedge CLK_24M);
		RST_4L = 1'b1;
		download_patterns();
		attr_readback();
		single_object();
		flipped_objects();
		overlap_priority();
		hit_limit();
		right_edge_clip();
		$display("Error count: %0d", err_cnt);
		if (err_cnt == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not complete within %0d ns", WATCHDOG_NS);
		$display("Error count: %0d", err_cnt);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
obj_pkg.sv
obj_attr_ram.sv
obj_pattern_rom.sv
obj_line_scan.sv
obj_row_render.sv
obj_line_buffer.sv
dkong_obj_top.sv
tb_obj.sv

//--- run.sh
#!/bin/sh
# Build and run the sprite engine testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns -f all.f --top-module tb_obj -o sim_obj
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_obj > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
	exit 1
fi
exit 0
